//--- rtl/csr_pkg.sv
`default_nettype none

package csr_pkg;

  //////////////////////////////
  // widths and reset values
  //////////////////////////////

  localparam int unsigned xlen      = 32;  // data word
  localparam int unsigned counter_w = 64;  // mcycle / minstret
  localparam int unsigned mcause_w  = 6;   // irq flag plus 5-bit code

  localparam logic [xlen-1:0] mtvec_reset = '1;

  // mstatus field positions
  localparam int unsigned mstatus_mie_bit  = 3;
  localparam int unsigned mstatus_mpie_bit = 7;
  localparam int unsigned mstatus_mpp_lo   = 11;  // mpp sits at 12:11

  // mie / mip bit positions
  localparam int unsigned irq_msi_bit = 3;
  localparam int unsigned irq_mti_bit = 7;
  localparam int unsigned irq_mei_bit = 11;
  localparam int unsigned irq_mfi_lo  = 16;   // fast irqs at 30:16
  localparam int unsigned n_fast_irq  = 15;

  //////////////////////////////
  // enums
  //////////////////////////////

  // implemented machine csrs only
  typedef enum logic [11:0] {
    csr_mstatus       = 12'h300,
    csr_mie           = 12'h304,
    csr_mtvec         = 12'h305,
    csr_mcountinhibit = 12'h320,
    csr_mscratch      = 12'h340,
    csr_mepc          = 12'h341,
    csr_mcause        = 12'h342,
    csr_mtval         = 12'h343,
    csr_mip           = 12'h344,
    csr_mcycle        = 12'hb00,
    csr_minstret      = 12'hb02,
    csr_mcycleh       = 12'hb80,
    csr_minstreth     = 12'hb82
  } csr_addr_e;

  typedef enum logic [1:0] {
    csr_op_read  = 2'b00,
    csr_op_write = 2'b01,
    csr_op_set   = 2'b10,
    csr_op_clear = 2'b11
  } csr_op_e;

  // core runs in machine mode only
  typedef enum logic [1:0] {
    priv_lvl_u = 2'b00,
    priv_lvl_s = 2'b01,
    priv_lvl_h = 2'b10,
    priv_lvl_m = 2'b11
  } priv_lvl_e;

  //////////////////////////////
  // structs
  //////////////////////////////

  typedef struct packed {
    logic             access;  // access strobe
    csr_addr_e        addr;
    csr_op_e          op;
    logic [xlen-1:0]  wdata;
  } csr_req_t;                 // 47 bits

  typedef struct packed {
    logic                   software;
    logic                   timer;
    logic                   external;
    logic [n_fast_irq-1:0]  fast;
  } irq_t;                     // 18 bits

  typedef struct packed {
    logic       mie;
    logic       mpie;
    priv_lvl_e  mpp;
  } mstatus_t;

  // trap controls from the core
  typedef struct packed {
    logic                 save_cause;    // trap entry
    logic                 save_if;       // mepc from if stage pc
    logic                 save_id;       // mepc from id stage pc
    logic                 restore_mret;
    logic [mcause_w-1:0]  cause;
    logic [xlen-1:0]      mtval;
  } trap_ctrl_t;               // 42 bits

  // one-hot write selects, at most one bit high
  typedef struct packed {
    logic mstatus;
    logic mie;
    logic mscratch;
    logic mepc;
    logic mcause;
    logic mtval;
    logic mtvec;
    logic mcountinhibit;
    logic mcycle;
    logic mcycleh;
    logic minstret;
    logic minstreth;
  } csr_wsel_t;

endpackage

`default_nettype wire

//--- rtl/csr_access.sv
`timescale 1ns/10ps
`default_nettype none

module csr_access (
  input  csr_pkg::csr_req_t         csr_req_i,
  input  logic                      instr_new_i,   // id stage sees a new instr
  input  logic [csr_pkg::xlen-1:0]  trap_rdata_i,
  input  logic [csr_pkg::xlen-1:0]  cnt_rdata_i,
  output logic [csr_pkg::xlen-1:0]  csr_rdata_o,
  output logic [csr_pkg::xlen-1:0]  csr_wdata_o,
  output csr_pkg::csr_wsel_t        csr_wsel_o,
  output logic                      illegal_o
);

  logic is_trap;   // address held by trap regs
  logic is_cnt;    // address held by counters
  logic unknown;
  logic wreq;      // op wants a write
  logic csr_we;    // write actually happens

  //////////////////////////////
  // address range decode
  //////////////////////////////

  always_comb begin
    is_trap = 1'b0;
    is_cnt  = 1'b0;
    case (csr_req_i.addr)
      csr_pkg::csr_mstatus,
      csr_pkg::csr_mie,
      csr_pkg::csr_mtvec,
      csr_pkg::csr_mscratch,
      csr_pkg::csr_mepc,
      csr_pkg::csr_mcause,
      csr_pkg::csr_mtval,
      csr_pkg::csr_mip:           is_trap = 1'b1;
      csr_pkg::csr_mcountinhibit,
      csr_pkg::csr_mcycle,
      csr_pkg::csr_mcycleh,
      csr_pkg::csr_minstret,
      csr_pkg::csr_minstreth:     is_cnt  = 1'b1;
      default: ;                  // hpm space and the rest
    endcase
  end

  assign unknown = ~(is_trap | is_cnt);

  // read word, zero for unknown
  assign csr_rdata_o = is_trap ? trap_rdata_i :
                       is_cnt  ? cnt_rdata_i  : '0;

  //////////////////////////////
  // write data from op
  //////////////////////////////

  always_comb begin
    case (csr_req_i.op)
      csr_pkg::csr_op_write: csr_wdata_o = csr_req_i.wdata;
      csr_pkg::csr_op_set:   csr_wdata_o = csr_req_i.wdata | csr_rdata_o;
      csr_pkg::csr_op_clear: csr_wdata_o = ~csr_req_i.wdata & csr_rdata_o;
      default:               csr_wdata_o = csr_req_i.wdata;  // read passes through
    endcase
  end

  assign wreq   = (csr_req_i.op != csr_pkg::csr_op_read);
  assign csr_we = wreq & instr_new_i;  // one cycle per instr

  // read-only space is addr[11:10] == 2'b11
  assign illegal_o = (csr_req_i.access & unknown) |
                     ((csr_req_i.addr[11:10] == 2'b11) & wreq);

  //////////////////////////////
  // write selects
  //////////////////////////////

  always_comb begin
    csr_wsel_o = '0;
    if (csr_we) begin
      case (csr_req_i.addr)
        csr_pkg::csr_mstatus:       csr_wsel_o.mstatus       = 1'b1;
        csr_pkg::csr_mie:           csr_wsel_o.mie           = 1'b1;
        csr_pkg::csr_mscratch:      csr_wsel_o.mscratch      = 1'b1;
        csr_pkg::csr_mepc:          csr_wsel_o.mepc          = 1'b1;
        csr_pkg::csr_mcause:        csr_wsel_o.mcause        = 1'b1;
        csr_pkg::csr_mtval:         csr_wsel_o.mtval         = 1'b1;
        csr_pkg::csr_mtvec:         csr_wsel_o.mtvec         = 1'b1;
        csr_pkg::csr_mcountinhibit: csr_wsel_o.mcountinhibit = 1'b1;
        csr_pkg::csr_mcycle:        csr_wsel_o.mcycle        = 1'b1;
        csr_pkg::csr_mcycleh:       csr_wsel_o.mcycleh       = 1'b1;
        csr_pkg::csr_minstret:      csr_wsel_o.minstret      = 1'b1;
        csr_pkg::csr_minstreth:     csr_wsel_o.minstreth     = 1'b1;
        default: ;                  // mip and unknowns hold nothing writable
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/csr_trap_regs.sv
`timescale 1ns/10ps
`default_nettype none

module csr_trap_regs (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  csr_pkg::csr_addr_e        addr_i,       // read decode only
  input  logic [csr_pkg::xlen-1:0]  csr_wdata_i,
  input  csr_pkg::csr_wsel_t        csr_wsel_i,
  input  csr_pkg::irq_t             irq_i,
  input  csr_pkg::trap_ctrl_t       trap_i,
  input  logic [csr_pkg::xlen-1:0]  pc_if_i,
  input  logic [csr_pkg::xlen-1:0]  pc_id_i,
  output logic [csr_pkg::xlen-1:0]  rdata_o,
  output csr_pkg::irq_t             mip_o,
  output logic                      irq_pending_o,
  output logic                      mstatus_mie_o,
  output logic [csr_pkg::xlen-1:0]  mepc_o,
  output logic [csr_pkg::xlen-1:0]  mtvec_o
);

  localparam int unsigned xlen = csr_pkg::xlen;
  localparam int unsigned cw   = csr_pkg::mcause_w;

  csr_pkg::mstatus_t mstatus_q, mstatus_d;
  csr_pkg::irq_t     mie_q, mie_d;
  logic [xlen-1:0]   mscratch_q, mscratch_d;
  logic [xlen-1:0]   mepc_q, mepc_d;
  logic [cw-1:0]     mcause_q, mcause_d;
  logic [xlen-1:0]   mtval_q, mtval_d;
  logic [xlen-1:0]   mtvec_q, mtvec_d;
  logic [xlen-1:0]   exception_pc;

  // irq struct to its mie/mip word layout
  function automatic logic [xlen-1:0] irq_to_word(input csr_pkg::irq_t irq);
    logic [xlen-1:0] w;
    w                                           = '0;
    w[csr_pkg::irq_msi_bit]                     = irq.software;
    w[csr_pkg::irq_mti_bit]                     = irq.timer;
    w[csr_pkg::irq_mei_bit]                     = irq.external;
    w[csr_pkg::irq_mfi_lo +: csr_pkg::n_fast_irq] = irq.fast;
    return w;
  endfunction

  function automatic csr_pkg::irq_t word_to_irq(input logic [xlen-1:0] w);
    csr_pkg::irq_t irq;
    irq.software = w[csr_pkg::irq_msi_bit];
    irq.timer    = w[csr_pkg::irq_mti_bit];
    irq.external = w[csr_pkg::irq_mei_bit];
    irq.fast     = w[csr_pkg::irq_mfi_lo +: csr_pkg::n_fast_irq];
    return irq;
  endfunction

  //////////////////////////////
  // interrupts
  //////////////////////////////

  assign mip_o         = csr_pkg::irq_t'(irq_i & mie_q);  // no flop, wakes on wfi
  assign irq_pending_o = |mip_o;

  //////////////////////////////
  // read mux
  //////////////////////////////

  always_comb begin
    rdata_o = '0;
    case (addr_i)
      csr_pkg::csr_mstatus: begin
        rdata_o[csr_pkg::mstatus_mie_bit]      = mstatus_q.mie;
        rdata_o[csr_pkg::mstatus_mpie_bit]     = mstatus_q.mpie;
        rdata_o[csr_pkg::mstatus_mpp_lo +: 2]  = mstatus_q.mpp;
      end
      csr_pkg::csr_mie:      rdata_o = irq_to_word(mie_q);
      csr_pkg::csr_mip:      rdata_o = irq_to_word(mip_o);
      csr_pkg::csr_mscratch: rdata_o = mscratch_q;
      csr_pkg::csr_mepc:     rdata_o = mepc_q;
      csr_pkg::csr_mcause:   rdata_o = {mcause_q[cw-1], {(xlen-cw){1'b0}}, mcause_q[cw-2:0]};
      csr_pkg::csr_mtval:    rdata_o = mtval_q;
      csr_pkg::csr_mtvec:    rdata_o = mtvec_q;
      default: ;             // counters answered elsewhere
    endcase
  end

  //////////////////////////////
  // next state
  //////////////////////////////

  // save_id is the fallback
  assign exception_pc = trap_i.save_if ? pc_if_i : pc_id_i;

  always_comb begin
    mstatus_d  = mstatus_q;
    mie_d      = mie_q;
    mscratch_d = mscratch_q;
    mepc_d     = mepc_q;
    mcause_d   = mcause_q;
    mtval_d    = mtval_q;
    mtvec_d    = mtvec_q;

    // software writes
    if (csr_wsel_i.mstatus) begin
      mstatus_d.mie  = csr_wdata_i[csr_pkg::mstatus_mie_bit];
      mstatus_d.mpie = csr_wdata_i[csr_pkg::mstatus_mpie_bit];
      mstatus_d.mpp  = csr_pkg::priv_lvl_m;             // m-mode only
    end
    if (csr_wsel_i.mie)      mie_d      = word_to_irq(csr_wdata_i);
    if (csr_wsel_i.mscratch) mscratch_d = csr_wdata_i;
    if (csr_wsel_i.mepc)     mepc_d     = {csr_wdata_i[xlen-1:1], 1'b0};
    if (csr_wsel_i.mcause)   mcause_d   = {csr_wdata_i[xlen-1], csr_wdata_i[cw-2:0]};
    if (csr_wsel_i.mtval)    mtval_d    = csr_wdata_i;
    if (csr_wsel_i.mtvec)    mtvec_d    = {csr_wdata_i[xlen-1:8], 8'h01};  // vectored

    // trap controller wins over software
    if (trap_i.save_cause) begin
      mepc_d         = exception_pc;
      mcause_d       = trap_i.cause;
      mtval_d        = trap_i.mtval;
      mstatus_d.mpie = mstatus_q.mie;
      mstatus_d.mie  = 1'b0;                           // mask irqs
      mstatus_d.mpp  = csr_pkg::priv_lvl_m;
    end else if (trap_i.restore_mret) begin
      mstatus_d.mie  = mstatus_q.mpie;
      mstatus_d.mpie = 1'b1;
    end
  end

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_q <= '{mie: 1'b0, mpie: 1'b0, mpp: csr_pkg::priv_lvl_m};
      mie_q     <= '0;
      mtvec_q   <= csr_pkg::mtvec_reset;
    end else begin
      mstatus_q <= mstatus_d;
      mie_q     <= mie_d;
      mtvec_q   <= mtvec_d;
    end
  end

  // payload words
  always_ff @(posedge clk_i) begin
    mscratch_q <= mscratch_d;
    mepc_q     <= mepc_d;
    mcause_q   <= mcause_d;
    mtval_q    <= mtval_d;
  end

  assign mstatus_mie_o = mstatus_q.mie;
  assign mepc_o        = mepc_q;
  assign mtvec_o       = mtvec_q;  // if stage jumps here

endmodule

`default_nettype wire

//--- rtl/csr_counters.sv
`timescale 1ns/10ps
`default_nettype none

module csr_counters (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  csr_pkg::csr_addr_e        addr_i,       // read decode only
  input  logic [csr_pkg::xlen-1:0]  csr_wdata_i,
  input  csr_pkg::csr_wsel_t        csr_wsel_i,
  input  logic                      instr_ret_i,  // instr retired this cycle
  output logic [csr_pkg::xlen-1:0]  rdata_o
);

  localparam int unsigned xlen = csr_pkg::xlen;
  localparam int unsigned cw   = csr_pkg::counter_w;

  logic [cw-1:0] mcycle_q, minstret_q;
  logic          inh_cy_q;   // mcountinhibit bit 0
  logic          inh_ir_q;   // mcountinhibit bit 2

  // a write of either half replaces the increment
  function automatic logic [cw-1:0] cnt_next(
    input logic [cw-1:0]   q,
    input logic            inc,
    input logic            we_lo,
    input logic            we_hi,
    input logic [xlen-1:0] wdata
  );
    logic [cw-1:0] d;
    d = q;
    if (we_lo) begin
      d[xlen-1:0] = wdata;
    end else if (we_hi) begin
      d[cw-1:xlen] = wdata;
    end else if (inc) begin
      d = q + 1'b1;
    end
    return d;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
      inh_cy_q   <= 1'b0;
      inh_ir_q   <= 1'b0;
    end else begin
      mcycle_q   <= cnt_next(mcycle_q, ~inh_cy_q, csr_wsel_i.mcycle,
                             csr_wsel_i.mcycleh, csr_wdata_i);
      minstret_q <= cnt_next(minstret_q, instr_ret_i & ~inh_ir_q, csr_wsel_i.minstret,
                             csr_wsel_i.minstreth, csr_wdata_i);
      if (csr_wsel_i.mcountinhibit) begin
        inh_cy_q <= csr_wdata_i[0];
        inh_ir_q <= csr_wdata_i[2];  // bit 1 (time) stays 0
      end
    end
  end

  // read back, hpm range never reaches here
  always_comb begin
    case (addr_i)
      csr_pkg::csr_mcountinhibit: rdata_o = {{(xlen-3){1'b0}}, inh_ir_q, 1'b0, inh_cy_q};
      csr_pkg::csr_mcycle:        rdata_o = mcycle_q[xlen-1:0];
      csr_pkg::csr_mcycleh:       rdata_o = mcycle_q[cw-1:xlen];
      csr_pkg::csr_minstret:      rdata_o = minstret_q[xlen-1:0];
      csr_pkg::csr_minstreth:     rdata_o = minstret_q[cw-1:xlen];
      default:                    rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/csr_top.sv
`timescale 1ns/10ps
`default_nettype none

module csr_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // access port from id stage
  input  csr_pkg::csr_req_t         csr_req_i,
  input  logic                      instr_new_i,
  // interrupts
  input  csr_pkg::irq_t             irq_i,
  // trap control
  input  csr_pkg::trap_ctrl_t       trap_i,
  input  logic [csr_pkg::xlen-1:0]  pc_if_i,
  input  logic [csr_pkg::xlen-1:0]  pc_id_i,
  input  logic                      instr_ret_i,
  output logic [csr_pkg::xlen-1:0]  csr_rdata_o,   // same cycle as request
  output logic                      illegal_o,
  output csr_pkg::irq_t             mip_o,
  output logic                      irq_pending_o,
  output logic                      mstatus_mie_o,
  output logic [csr_pkg::xlen-1:0]  mepc_o,
  output logic [csr_pkg::xlen-1:0]  mtvec_o
);

  logic [csr_pkg::xlen-1:0] csr_wdata;   // after set/clear
  csr_pkg::csr_wsel_t       csr_wsel;
  logic [csr_pkg::xlen-1:0] trap_rdata;
  logic [csr_pkg::xlen-1:0] cnt_rdata;

  //////////////////////////////
  // access decode
  //////////////////////////////

  csr_access csr_access_i (
    .csr_req_i    (csr_req_i),
    .instr_new_i  (instr_new_i),
    .trap_rdata_i (trap_rdata),
    .cnt_rdata_i  (cnt_rdata),
    .csr_rdata_o  (csr_rdata_o),
    .csr_wdata_o  (csr_wdata),
    .csr_wsel_o   (csr_wsel),
    .illegal_o    (illegal_o)
  );

  //////////////////////////////
  // register blocks
  //////////////////////////////

  csr_trap_regs csr_trap_regs_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .addr_i        (csr_req_i.addr),
    .csr_wdata_i   (csr_wdata),
    .csr_wsel_i    (csr_wsel),
    .irq_i         (irq_i),
    .trap_i        (trap_i),
    .pc_if_i       (pc_if_i),
    .pc_id_i       (pc_id_i),
    .rdata_o       (trap_rdata),
    .mip_o         (mip_o),
    .irq_pending_o (irq_pending_o),
    .mstatus_mie_o (mstatus_mie_o),
    .mepc_o        (mepc_o),
    .mtvec_o       (mtvec_o)
  );

  csr_counters csr_counters_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .addr_i      (csr_req_i.addr),
    .csr_wdata_i (csr_wdata),
    .csr_wsel_i  (csr_wsel),
    .instr_ret_i (instr_ret_i),
    .rdata_o     (cnt_rdata)
  );

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam time half_period = 20ns;  // 40 ns clock

  initial begin
    clk_o = 1'b0;
    forever #(half_period) clk_o = ~clk_o;
  end

  // reset held low for 4 rising edges
  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

//--- tests/csr_tb.sv
`timescale 1ns/10ps
`default_nettype none

module csr_tb;

  localparam int unsigned max_cycles = 1000;  // watchdog bound
  localparam int unsigned reset_wait = 20;

  logic                     clk, rst_n;
  csr_pkg::csr_req_t        csr_req;
  logic                     instr_new, instr_ret;
  csr_pkg::irq_t            irq;
  csr_pkg::trap_ctrl_t      trap;
  logic [csr_pkg::xlen-1:0] pc_if, pc_id;
  logic [csr_pkg::xlen-1:0] rdata, mepc, mtvec;
  logic                     illegal, irq_pending, mstatus_mie;
  csr_pkg::irq_t            mip;

  tb_clk_gen clk_gen_i (.clk_o(clk), .rst_no(rst_n));

  csr_top csr_top_i (
    .clk_i(clk), .rst_ni(rst_n), .csr_req_i(csr_req), .instr_new_i(instr_new),
    .irq_i(irq), .trap_i(trap), .pc_if_i(pc_if), .pc_id_i(pc_id),
    .instr_ret_i(instr_ret), .csr_rdata_o(rdata), .illegal_o(illegal), .mip_o(mip),
    .irq_pending_o(irq_pending), .mstatus_mie_o(mstatus_mie), .mepc_o(mepc),
    .mtvec_o(mtvec)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else fail_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  // mie / mip layout: msi 3, mti 7, mei 11, fast 30:16
  function automatic logic [31:0] irq_word(input csr_pkg::irq_t i);
    logic [31:0] w;
    w        = '0;
    w[3]     = i.software;
    w[7]     = i.timer;
    w[11]    = i.external;
    w[30:16] = i.fast;
    return w;
  endfunction

  task automatic drive_idle();
    csr_req   <= '{access: 1'b0, addr: csr_pkg::csr_mstatus, op: csr_pkg::csr_op_read,
                   wdata: '0};
    instr_new <= 1'b0;
    instr_ret <= 1'b0;
    trap      <= '0;
    pc_if     <= '0;
    pc_id     <= '0;
  endtask

  task automatic drive_req(input logic [11:0] addr, input csr_pkg::csr_op_e op,
                           input logic [31:0] data);
    csr_req.access <= 1'b1;
    csr_req.addr   <= csr_pkg::csr_addr_e'(addr);
    csr_req.op     <= op;
    csr_req.wdata  <= data;
    instr_new      <= 1'b1;
  endtask

  // cycle limit, independent of the stimulus
  initial begin
    for (int unsigned n = 0; n < max_cycles; n++) @(posedge clk);
    fail_run("simulation ran past the cycle limit");
  end

  //////////////////////////////
  // stimulus from data file
  //////////////////////////////

  initial begin
    int            fd, code, cnt, lineno;
    int unsigned   rnd;
    string         line, name;
    byte           cmd;
    logic [31:0]   addr, data, data2, exp, mip_exp;
    csr_pkg::irq_t irq_val;

    void'($urandom(46));  // fixed seed for irq levels
    irq = '0;
    drive_idle();
    lineno = 0;

    for (int unsigned n = 0; n < reset_wait && rst_n !== 1'b1; n++) @(negedge clk);
    if (rst_n !== 1'b1) fail_run("reset was never released");
    check_val("reset irq_pending", 32'd0, {31'd0, irq_pending});
    check_val("reset mstatus_mie", 32'd0, {31'd0, mstatus_mie});

    fd = $fopen("tests/csr_input.txt", "r");
    if (fd == 0) fail_run("could not open tests/csr_input.txt");
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      lineno++;
      if (code != 0 && line.len() > 2 && line[0] != "#") begin
        cnt = $sscanf(line, "%c %h %h %h %h", cmd, addr, data, data2, exp);
        if (cnt != 5) fail_run($sformatf("malformed data file line %0d", lineno));
        name = $sformatf("%c %03h line %0d", cmd, addr[11:0], lineno);
        case (cmd)
          "W", "S", "C": begin  // expect column is illegal_o
            @(posedge clk);
            drive_idle();
            drive_req(addr[11:0], (cmd == "W") ? csr_pkg::csr_op_write :
                                  (cmd == "S") ? csr_pkg::csr_op_set : csr_pkg::csr_op_clear,
                      data);
            @(negedge clk);
            check_val(name, exp, {31'd0, illegal});
          end
          "R": begin
            @(posedge clk);
            drive_idle();
            drive_req(addr[11:0], csr_pkg::csr_op_read, '0);
            @(negedge clk);
            check_val(name, exp, rdata);
            case (addr[11:0])  // registers with their own output
              12'h300: check_val({name, " mstatus_mie_o"}, {31'd0, exp[3]},
                                 {31'd0, mstatus_mie});
              12'h305: check_val({name, " mtvec_o"}, exp, mtvec);
              12'h341: check_val({name, " mepc_o"}, exp, mepc);
              default: ;
            endcase
          end
          "T": begin  // addr column holds the cause
            @(posedge clk);
            drive_idle();
            trap.save_cause <= 1'b1;
            trap.save_if    <= 1'b1;
            trap.cause      <= addr[5:0];
            trap.mtval      <= data;
            pc_if           <= data2;
            pc_id           <= ~data2;  // must not be picked
          end
          "M": begin
            @(posedge clk);
            drive_idle();
            trap.restore_mret <= 1'b1;
          end
          "I": begin  // data = enabled mie word, data2 = rounds
            for (int unsigned r = 0; r < data2; r++) begin
              rnd     = $urandom;
              irq_val = rnd[17:0];
              @(posedge clk);
              drive_idle();
              irq <= irq_val;
              drive_req(addr[11:0], csr_pkg::csr_op_read, '0);
              @(negedge clk);
              mip_exp = irq_word(irq_val) & data;
              check_val({name, " mip"}, mip_exp, rdata);
              check_val({name, " mip_o"}, mip_exp, irq_word(mip));
              check_val({name, " pending"}, {31'd0, |mip_exp}, {31'd0, irq_pending});
            end
          end
          "N": begin  // retire for data2 cycles
            for (int unsigned r = 0; r < data2; r++) begin
              @(posedge clk);
              drive_idle();
              instr_ret <= 1'b1;
            end
          end
          default: fail_run($sformatf("unknown command on data file line %0d", lineno));
        endcase
      end
    end
    $fclose(fd);

    @(posedge clk);
    drive_idle();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/csr_input.txt
# cmd addr data data2 expect, hex; W/S/C expect illegal_o, R expect read data
# T: addr=cause data=mtval data2=pc; I: data=mie word data2=rounds; N: data2=cycles
R 305 0 0 ffffffff
R 300 0 0 00001800
R 304 0 0 00000000
W 340 a5a50f0f 0 0
R 340 0 0 a5a50f0f
S 340 00f000f0 0 0
R 340 0 0 a5f50fff
C 340 a0000f00 0 0
R 340 0 0 05f500ff
R 340 0 0 05f500ff
W 305 12345678 0 0
R 305 0 0 12345601
W 341 80000003 0 0
R 341 0 0 80000002
W 342 ffffffff 0 0
R 342 0 0 8000001f
W 300 00000008 0 0
R 300 0 0 00001808
T 00b deadbeef 00000404 0
R 341 0 0 00000404
R 342 0 0 0000000b
R 343 0 0 deadbeef
R 300 0 0 00001880
M 0 0 0 0
R 300 0 0 00001888
W 304 55550808 0 0
R 304 0 0 55550808
I 344 55550808 10 0
W 320 00000007 0 0
R 320 0 0 00000005
W b00 11112222 0 0
W b80 33334444 0 0
W b02 55556666 0 0
R b00 0 0 11112222
R b80 0 0 33334444
R b02 0 0 55556666
W 320 00000001 0 0
N 0 0 9 0
R b02 0 0 5555666f
R b00 0 0 11112222
W b03 0 0 1
W c00 0 0 1
W 340 0 0 0

//--- build.f
rtl/csr_pkg.sv
rtl/csr_access.sv
rtl/csr_trap_regs.sv
rtl/csr_counters.sv
rtl/csr_top.sv
tests/tb_clk_gen.sv
tests/csr_tb.sv

//--- Bender.yml
package:
  name: csr

sources:
  - rtl/csr_pkg.sv
  - rtl/csr_access.sv
  - rtl/csr_trap_regs.sv
  - rtl/csr_counters.sv
  - rtl/csr_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/csr_tb.sv
